/* zx_ports_pkg.sv */
package zx_ports_pkg;

	typedef logic [7:0]  byte_t;   // data bus / register byte
	typedef logic [15:0] addr_t;   // z80 i/o address
	typedef logic [5:0]  border_t; // border as the video block wants it
	typedef logic [5:0]  page_t;   // pentagon-1m page number

	////////////////////
	// port low bytes
	////////////////////
	localparam byte_t PORT_FE = 8'hFE;
	localparam byte_t PORT_FD = 8'hFD;
	localparam byte_t PORT_F7 = 8'hF7;
	localparam byte_t PORT_DF = 8'hDF; // kempston mouse
	localparam byte_t PORT_1F = 8'h1F; // kempston joystick / soundrive ch1
	localparam byte_t PORT_0F = 8'h0F;
	localparam byte_t PORT_4F = 8'h4F;
	localparam byte_t PORT_5F = 8'h5F;
	localparam byte_t PORT_FB = 8'hFB; // covox
	localparam byte_t PORT_DD = 8'hDD; // covox alias
	localparam byte_t PORT_EF = 8'hEF; // xt readback

	// extended register numbers
	localparam byte_t XREG_BORDER  = 8'h00;
	localparam byte_t XREG_VCONFIG = 8'h08;

	typedef struct packed {
		logic  wr;   // one-cycle write strobe
		logic  rd;   // one-cycle read strobe
		addr_t addr;
		byte_t data;
	} io_cycle_t;

	typedef struct packed {
		logic       fe;
		logic       p7ffd;
		logic       peff7;
		logic       xt;
		logic [3:0] dac_ch; // one-hot, all set for covox
		logic       other;  // anything but the xt port
	} port_sel_t;

	typedef struct packed {
		byte_t ch0;
		byte_t ch1;
		byte_t ch2;
		byte_t ch3;
	} dac_levels_t;

	typedef struct packed {
		byte_t p7ffd;
		byte_t peff7;
		page_t page;
		logic  rom;
		logic  ram0_0;
		logic  one_meg_on;
		logic  spare;
	} paging_t;

endpackage

/* io_strobe.sv */
`timescale 1ns/100ps

module io_strobe (
	input  logic                    zclk,
	input  logic                    rst_n,
	input  zx_ports_pkg::addr_t     a,
	input  zx_ports_pkg::byte_t     din,
	input  logic                    iorq_n,
	input  logic                    rd_n,
	input  logic                    wr_n,
	output zx_ports_pkg::io_cycle_t cyc
);
	import zx_ports_pkg::*;

	logic  io_wr_now;
	logic  io_rd_now;
	logic  io_wr_prev;
	logic  io_rd_prev;
	logic  wr_q;
	logic  rd_q;
	addr_t addr_q;
	byte_t data_q;

	assign io_wr_now = ~(iorq_n | wr_n);
	assign io_rd_now = ~(iorq_n | rd_n);

	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			io_wr_prev <= 1'b0;
			io_rd_prev <= 1'b0;
			wr_q       <= 1'b0;
			rd_q       <= 1'b0;
		end
		else
		begin
			io_wr_prev <= io_wr_now;
			io_rd_prev <= io_rd_now;
			wr_q       <= io_wr_now & ~io_wr_prev; // first sampled cycle only
			rd_q       <= io_rd_now & ~io_rd_prev;
		end
	end

	// bus snapshot taken on the same edge as the strobe
	always_ff @(posedge zclk)
	begin
		addr_q <= a;
		data_q <= din;
	end

	assign cyc = '{wr: wr_q, rd: rd_q, addr: addr_q, data: data_q};

	a_no_wr_rd_overlap: assert property (@(posedge zclk) disable iff (!rst_n)
		!(wr_q && rd_q));
	a_wr_single: assert property (@(posedge zclk) disable iff (!rst_n) wr_q |=> !wr_q);
	a_rd_single: assert property (@(posedge zclk) disable iff (!rst_n) rd_q |=> !rd_q);

endmodule

/* port_decode.sv */
`timescale 1ns/100ps

module port_decode #(
	parameter zx_ports_pkg::addr_t XT_PORT = 16'h55FF
) (
	input  zx_ports_pkg::addr_t     a,
	input  logic                    iorq_n,
	input  logic                    rd_n,
	input  zx_ports_pkg::io_cycle_t cyc,
	input  logic                    dos,
	input  logic [4:0]              keys_in,
	input  logic                    tape_read,
	input  logic [4:0]              kj_in,
	input  zx_ports_pkg::byte_t     mus_in,
	input  zx_ports_pkg::byte_t     xt_addr,
	input  zx_ports_pkg::border_t   border,
	output zx_ports_pkg::port_sel_t sel,
	output logic                    porthit,
	output logic                    dataout,
	output zx_ports_pkg::byte_t     dout
);
	import zx_ports_pkg::*;

	byte_t loa;     // live bus low byte
	byte_t cyc_loa; // low byte captured with the strobe
	logic  ext_port;

	assign loa     = a[7:0];
	assign cyc_loa = cyc.addr[7:0];

	////////////////////
	// live bus side
	////////////////////
	always_comb
	begin
		case (loa)
			PORT_FE, PORT_FD, PORT_DF, PORT_FB, PORT_DD, PORT_EF:
				porthit = 1'b1;
			PORT_F7, PORT_1F, PORT_0F, PORT_4F, PORT_5F:
				porthit = ~dos; // not in shadow
			default:
				porthit = 1'b0;
		endcase
	end

	assign ext_port = (loa == PORT_FD) && (a[15:14] == 2'b11); // fffd stays on the bus
	assign dataout  = porthit & ~iorq_n & ~rd_n & ~ext_port;

	always_comb
	begin
		case (loa)
			PORT_FE: dout = {1'b1, tape_read, 1'b0, keys_in};
			PORT_1F: dout = dos ? 8'hFF : {3'b000, kj_in};
			PORT_DF: dout = mus_in;
			PORT_EF: dout = (xt_addr == XREG_BORDER) ? {2'b00, border} : 8'hFF;
			default: dout = 8'hFF;
		endcase
	end

	////////////////////
	// write selects
	////////////////////
	always_comb
	begin
		sel       = '0;
		sel.fe    = (cyc_loa == PORT_FE);
		sel.p7ffd = (cyc_loa == PORT_FD) && !cyc.addr[15];
		sel.peff7 = (cyc_loa == PORT_F7) && !cyc.addr[12] && !dos;
		sel.xt    = (cyc.addr == XT_PORT);
		sel.other = (cyc.addr != XT_PORT); // breaks the xt sequence
		case (cyc_loa)
			PORT_0F:          sel.dac_ch = dos ? 4'b0000 : 4'b0001;
			PORT_1F:          sel.dac_ch = dos ? 4'b0000 : 4'b0010;
			PORT_4F:          sel.dac_ch = dos ? 4'b0000 : 4'b0100;
			PORT_5F:          sel.dac_ch = dos ? 4'b0000 : 4'b1000;
			PORT_FB, PORT_DD: sel.dac_ch = 4'b1111; // covox hits all four
			default:          sel.dac_ch = 4'b0000;
		endcase
	end

endmodule

/* xt_sequencer.sv */
`timescale 1ns/100ps

module xt_sequencer #(
	parameter zx_ports_pkg::byte_t XT_KEY = 8'hAA
) (
	input  logic                    zclk,
	input  logic                    rst_n,
	input  zx_ports_pkg::io_cycle_t cyc,
	input  zx_ports_pkg::port_sel_t sel,
	output logic                    xt_we,
	output zx_ports_pkg::byte_t     xt_addr
);
	import zx_ports_pkg::*;

	typedef enum logic [1:0] {
		XT_IDLE,
		XT_ADDR,
		XT_DATA
	} xt_state_t;

	xt_state_t state;
	logic      xt_wr;

	assign xt_wr = cyc.wr & sel.xt;
	assign xt_we = xt_wr & (state == XT_DATA); // data goes straight to the regs

	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state   <= XT_IDLE;
			xt_addr <= '0;
		end
		else if (cyc.wr && sel.other)
			state <= XT_IDLE; // any foreign write drops the sequence
		else if (xt_wr)
		begin
			case (state)
				XT_IDLE:
					if (cyc.data == XT_KEY)
						state <= XT_ADDR;
				XT_ADDR:
				begin
					xt_addr <= cyc.data;
					state   <= XT_DATA;
				end
				default:
					state <= XT_IDLE;
			endcase
		end
	end

	// data write only after key and index
	a_we_in_data: assert property (@(posedge zclk) disable iff (!rst_n)
		xt_we |-> $past(state) != XT_IDLE);

endmodule

/* paging_regs.sv */
`timescale 1ns/100ps

module paging_regs (
	input  logic                    zclk,
	input  logic                    rst_n,
	input  zx_ports_pkg::io_cycle_t cyc,
	input  zx_ports_pkg::port_sel_t sel,
	output zx_ports_pkg::paging_t   paging
);
	import zx_ports_pkg::*;

	byte_t p7ffd_r;
	byte_t peff7_r;
	logic  block1m; // eff7.2
	logic  lock_7ffd;

	assign block1m   = peff7_r[2];
	assign lock_7ffd = p7ffd_r[5] & block1m; // 48k lock only holds in 128k mode

	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			p7ffd_r <= '0;
			peff7_r <= '0;
		end
		else if (cyc.wr)
		begin
			if (sel.p7ffd && !lock_7ffd)
				p7ffd_r <= cyc.data;
			if (sel.peff7)
				peff7_r <= cyc.data;
		end
	end

	assign paging.p7ffd = block1m ? {3'b000, p7ffd_r[4:0]} : p7ffd_r;
	assign paging.peff7 = block1m ?
		{peff7_r[7], 1'b0, peff7_r[5:4], 3'b000, peff7_r[0]} : peff7_r;
	assign paging.page       = {p7ffd_r[7:5], p7ffd_r[2:0]};
	assign paging.rom        = p7ffd_r[4];
	assign paging.ram0_0     = peff7_r[3];
	assign paging.one_meg_on = ~block1m;
	assign paging.spare      = 1'b0;

	a_lock_holds: assert property (@(posedge zclk) disable iff (!rst_n)
		lock_7ffd |=> $stable(p7ffd_r));

endmodule

/* sound_border_regs.sv */
`timescale 1ns/100ps

module sound_border_regs (
	input  logic                      zclk,
	input  logic                      rst_n,
	input  zx_ports_pkg::io_cycle_t   cyc,
	input  zx_ports_pkg::port_sel_t   sel,
	input  logic                      xt_we,
	input  zx_ports_pkg::byte_t       xt_addr,
	output zx_ports_pkg::border_t     border,
	output zx_ports_pkg::byte_t       vcfg,
	output zx_ports_pkg::dac_levels_t dac
);
	import zx_ports_pkg::*;

	logic  beep; // fe.4
	logic  tout; // fe.3
	byte_t d;

	assign d    = cyc.data;
	assign beep = d[4];
	assign tout = d[3];

	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			border <= '0;
			vcfg   <= '0;
			dac    <= '0;
		end
		else
		begin
			////////////////////
			// port fe
			////////////////////
			if (cyc.wr && sel.fe)
			begin
				border  <= {d[1], 1'b0, d[2], 1'b0, d[0], 1'b0};
				dac.ch0 <= {8{beep}};
				dac.ch1 <= {8{beep}};
				dac.ch2 <= {beep, {7{tout}}};
				dac.ch3 <= {8{tout}};
			end

			// covox / soundrive
			if (cyc.wr && sel.dac_ch[0])
				dac.ch0 <= d;
			if (cyc.wr && sel.dac_ch[1])
				dac.ch1 <= d;
			if (cyc.wr && sel.dac_ch[2])
				dac.ch2 <= d;
			if (cyc.wr && sel.dac_ch[3])
				dac.ch3 <= d;

			if (xt_we)
			begin
				if (xt_addr == XREG_BORDER)
					border <= d[5:0];
				if (xt_addr == XREG_VCONFIG)
					vcfg <= d;
			end
		end
	end

endmodule

/* zx_ports_top.sv */
`timescale 1ns/100ps

module zx_ports_top #(
	parameter zx_ports_pkg::addr_t XT_PORT = 16'h55FF,
	parameter zx_ports_pkg::byte_t XT_KEY  = 8'hAA
) (
	input  logic                      zclk,
	input  logic                      rst_n,
	input  zx_ports_pkg::addr_t       a,
	input  zx_ports_pkg::byte_t       din,
	input  logic                      iorq_n,
	input  logic                      rd_n,
	input  logic                      wr_n,
	input  logic                      dos,
	input  logic [4:0]                keys_in,
	input  logic                      tape_read,
	input  logic [4:0]                kj_in,
	input  zx_ports_pkg::byte_t       mus_in,
	output zx_ports_pkg::byte_t       dout,
	output logic                      dataout,
	output logic                      porthit,
	output zx_ports_pkg::border_t     border,
	output zx_ports_pkg::byte_t       vcfg,
	output zx_ports_pkg::dac_levels_t dac,
	output zx_ports_pkg::paging_t     paging
);
	import zx_ports_pkg::*;

	io_cycle_t cyc;
	port_sel_t sel;
	logic      xt_we;
	byte_t     xt_addr;

	io_strobe u_strobe (.zclk, .rst_n, .a, .din, .iorq_n, .rd_n, .wr_n, .cyc);

	port_decode #(.XT_PORT(XT_PORT)) u_decode (
		.a, .iorq_n, .rd_n, .cyc, .dos, .keys_in, .tape_read, .kj_in, .mus_in,
		.xt_addr, .border, .sel, .porthit, .dataout, .dout
	);

	xt_sequencer #(.XT_KEY(XT_KEY)) u_xt (.zclk, .rst_n, .cyc, .sel, .xt_we, .xt_addr);

	paging_regs u_paging (.zclk, .rst_n, .cyc, .sel, .paging);

	sound_border_regs u_snd (
		.zclk, .rst_n, .cyc, .sel, .xt_we, .xt_addr, .border, .vcfg, .dac
	);

endmodule

/* tb_bus_tasks.svh */
`ifndef TB_BUS_TASKS_SVH
`define TB_BUS_TASKS_SVH

localparam int STROBE_TIMEOUT = 8; // cycles

// xorshift32, state kept in rng
function automatic logic [31:0] next_random();
	rng = rng ^ (rng << 13);
	rng = rng ^ (rng >> 17);
	rng = rng ^ (rng << 5);
	return rng;
endfunction

// poll for the strobe from io_strobe
task automatic wait_strobe(input logic want_wr);
	int   n;
	logic seen;
	n    = 0;
	seen = 1'b0;
	while (!seen && n < STROBE_TIMEOUT)
	begin
		@(negedge zclk);
		seen = want_wr ? uut.cyc.wr : uut.cyc.rd;
		n++;
	end
	if (!seen)
	begin
		err_other++;
		$display("timeout in %s: no %s strobe seen within %0d cycles", test_name,
			want_wr ? "write" : "read", STROBE_TIMEOUT);
	end
endtask

////////////////////
// z80 i/o cycles
////////////////////
task automatic write_port(input addr_t addr, input byte_t data);
	@(negedge zclk);
	bus_busy = 1'b1; // register checks paused
	a        = addr;
	din      = data;
	iorq_n   = 1'b0;
	wr_n     = 1'b0;
	wait_strobe(1'b1);
	repeat (2) @(negedge zclk); // three cycles low in all
	iorq_n = 1'b1;
	wr_n   = 1'b1;
	repeat (2) @(negedge zclk);
	model_write(addr, data);
	bus_busy = 1'b0;
endtask

task automatic read_port(input addr_t addr);
	@(negedge zclk);
	a      = addr;
	iorq_n = 1'b0;
	rd_n   = 1'b0;
	expect_read(addr);
	rd_chk = 1'b1;
	wait_strobe(1'b0);
	repeat (2) @(negedge zclk);
	rd_chk = 1'b0;
	iorq_n = 1'b1;
	rd_n   = 1'b1;
	repeat (2) @(negedge zclk);
endtask

// key, register index, value
task automatic run_xt_sequence(input byte_t key, input byte_t idx, input byte_t value);
	write_port(XT_PORT, key);
	write_port(XT_PORT, idx);
	write_port(XT_PORT, value);
endtask

`endif

/* tb_zx_ports.sv */
`timescale 1ns/100ps

module tb_zx_ports;
	import zx_ports_pkg::*;

	localparam addr_t XT_PORT = 16'h55FF;
	localparam byte_t XT_KEY  = 8'hAA;
	localparam byte_t WR_PORTS [7] = '{PORT_FE, PORT_FB, PORT_DD, PORT_0F, PORT_1F,
		PORT_4F, PORT_5F};

	typedef enum logic [1:0] {M_IDLE, M_ADDR, M_DATA} model_xt_t;

	logic        zclk = 1'b0;
	logic        rst_n;
	addr_t       a;
	byte_t       din;
	logic        iorq_n;
	logic        rd_n;
	logic        wr_n;
	logic        dos;
	logic [4:0]  keys_in;
	logic        tape_read;
	logic [4:0]  kj_in;
	byte_t       mus_in;
	byte_t       dout;
	logic        dataout;
	logic        porthit;
	border_t     border;
	byte_t       vcfg;
	dac_levels_t dac;
	paging_t     paging;

	// reference model
	byte_t       m_7ffd;
	byte_t       m_eff7;
	byte_t       m_xt_addr;
	model_xt_t   m_xt;
	border_t     exp_border;
	byte_t       exp_vcfg;
	dac_levels_t exp_dac;
	paging_t     exp_paging;
	logic        exp_porthit;
	logic        exp_dataout;
	byte_t       exp_dout;

	logic        bus_busy;
	logic        rd_chk;
	logic [31:0] rng;
	int          err_values = 0;
	int          err_other = 0;
	string       test_name;

	always #4 zclk = ~zclk;

	zx_ports_top #(.XT_PORT(XT_PORT), .XT_KEY(XT_KEY)) uut (
		.zclk, .rst_n, .a, .din, .iorq_n, .rd_n, .wr_n, .dos, .keys_in, .tape_read,
		.kj_in, .mus_in, .dout, .dataout, .porthit, .border, .vcfg, .dac, .paging
	);

	`include "tb_bus_tasks.svh"

	function automatic void report_value(input string what, input logic [31:0] exp,
		input logic [31:0] act);
		err_values++;
		$display("** Error %s: %s expected %h, actual %h", test_name, what, exp, act);
	endfunction

	function automatic paging_t paging_of(input byte_t p7, input byte_t pe);
		paging_t p;
		p.p7ffd      = pe[2] ? {3'b000, p7[4:0]} : p7; // 1 MB off masks the high page
		p.peff7      = pe[2] ? (pe & 8'hB1) : pe;
		p.page       = {p7[7:5], p7[2:0]};
		p.rom        = p7[4];
		p.ram0_0     = pe[3];
		p.one_meg_on = ~pe[2];
		p.spare      = 1'b0;
		return p;
	endfunction

	function automatic void model_write(input addr_t addr, input byte_t d);
		byte_t lo;
		lo = addr[7:0];
		if (lo == PORT_FE)
		begin
			exp_border  = {d[1], 1'b0, d[2], 1'b0, d[0], 1'b0};
			exp_dac.ch0 = {8{d[4]}};
			exp_dac.ch1 = {8{d[4]}};
			exp_dac.ch2 = {d[4], {7{d[3]}}};
			exp_dac.ch3 = {8{d[3]}};
		end
		if (lo == PORT_FB || lo == PORT_DD)
			exp_dac = {4{d}};
		if (!dos)
		begin
			if (lo == PORT_0F) exp_dac.ch0 = d;
			if (lo == PORT_1F) exp_dac.ch1 = d;
			if (lo == PORT_4F) exp_dac.ch2 = d;
			if (lo == PORT_5F) exp_dac.ch3 = d;
			if (lo == PORT_F7 && !addr[12]) m_eff7 = d;
		end
		if (lo == PORT_FD && !addr[15] && !(m_7ffd[5] && m_eff7[2]))
			m_7ffd = d;
		if (addr != XT_PORT)
			m_xt = M_IDLE;
		else if (m_xt == M_IDLE)
			m_xt = (d == XT_KEY) ? M_ADDR : M_IDLE;
		else if (m_xt == M_ADDR)
		begin
			m_xt_addr = d;
			m_xt      = M_DATA;
		end
		else
		begin
			if (m_xt_addr == XREG_BORDER) exp_border = d[5:0];
			if (m_xt_addr == XREG_VCONFIG) exp_vcfg = d;
			m_xt = M_IDLE;
		end
		exp_paging = paging_of(m_7ffd, m_eff7);
	endfunction

	function automatic void expect_read(input addr_t addr);
		case (addr[7:0])
			PORT_FE, PORT_FD, PORT_DF, PORT_FB, PORT_DD, PORT_EF: exp_porthit = 1'b1;
			PORT_F7, PORT_1F, PORT_0F, PORT_4F, PORT_5F:          exp_porthit = ~dos;
			default:                                              exp_porthit = 1'b0;
		endcase
		exp_dataout = exp_porthit && (addr != 16'hFFFD);
		exp_dout    = 8'hFF;
		if (addr[7:0] == PORT_FE) exp_dout = {1'b1, tape_read, 1'b0, keys_in};
		if (addr[7:0] == PORT_1F && !dos) exp_dout = {3'b000, kj_in};
		if (addr[7:0] == PORT_DF) exp_dout = mus_in;
		if (addr[7:0] == PORT_EF && m_xt_addr == XREG_BORDER) exp_dout = {2'b00, exp_border};
	endfunction

	////////////////////
	// checks
	////////////////////
	a_border: assert property (@(posedge zclk) disable iff (!rst_n)
		!bus_busy |-> border == exp_border)
		else report_value("border", 32'($sampled(exp_border)), 32'($sampled(border)));
	a_vcfg: assert property (@(posedge zclk) disable iff (!rst_n)
		!bus_busy |-> vcfg == exp_vcfg)
		else report_value("vcfg", 32'($sampled(exp_vcfg)), 32'($sampled(vcfg)));
	a_dac: assert property (@(posedge zclk) disable iff (!rst_n)
		!bus_busy |-> dac == exp_dac)
		else report_value("dac", 32'($sampled(exp_dac)), 32'($sampled(dac)));
	a_paging: assert property (@(posedge zclk) disable iff (!rst_n)
		!bus_busy |-> paging == exp_paging)
		else report_value("paging", 32'($sampled(exp_paging)), 32'($sampled(paging)));
	a_porthit: assert property (@(posedge zclk) disable iff (!rst_n)
		rd_chk |-> porthit == exp_porthit)
		else report_value("porthit", 32'($sampled(exp_porthit)), 32'($sampled(porthit)));
	a_dataout: assert property (@(posedge zclk) disable iff (!rst_n)
		rd_chk |-> dataout == exp_dataout)
		else report_value("dataout", 32'($sampled(exp_dataout)), 32'($sampled(dataout)));
	a_dout: assert property (@(posedge zclk) disable iff (!rst_n)
		rd_chk |-> dout == exp_dout)
		else report_value("dout", 32'($sampled(exp_dout)), 32'($sampled(dout)));
	a_idle_bus: assert property (@(posedge zclk) disable iff (!rst_n)
		iorq_n |-> !dataout)
		else report_value("dataout idle", 32'(0), 32'($sampled(dataout)));

	initial
	begin
		logic [31:0] r;
		rst_n = 1'b0;
		a = '0;
		din = '0;
		iorq_n = 1'b1;
		rd_n = 1'b1;
		wr_n = 1'b1;
		dos = 1'b0;
		keys_in = '0;
		tape_read = 1'b0;
		kj_in = '0;
		mus_in = '0;
		bus_busy = 1'b0;
		rd_chk = 1'b0;
		rng = 32'h1b170456;
		m_7ffd = '0;
		m_eff7 = '0;
		m_xt_addr = '0;
		m_xt = M_IDLE;
		exp_border = '0;
		exp_vcfg = '0;
		exp_dac = '0;
		exp_paging = paging_of(8'h00, 8'h00);
		test_name = "reset";
		repeat (3) @(posedge zclk);
		@(negedge zclk);
		rst_n = 1'b1;
		repeat (4) @(negedge zclk);

		test_name = "read_decode";
		r = next_random();
		keys_in = r[4:0];
		tape_read = r[5];
		kj_in = r[12:8];
		mus_in = r[23:16];
		read_port({r[31:24], PORT_FE});
		read_port({r[15:8], PORT_DF});
		read_port({r[23:16], PORT_1F});
		dos = 1'b1;
		read_port({r[7:0], PORT_1F}); // shadow hides the joystick
		dos = 1'b0;
		read_port(16'h7FFD);
		read_port(16'hFFFD); // external port keeps dataout low
		r = next_random();
		read_port({r[15:8], r[7:4], 4'h2}); // no port ends in 2

		test_name = "fe_dac";
		for (int i = 0; i < 21; i++)
		begin
			r = next_random();
			write_port({r[15:8], WR_PORTS[i % 7]}, r[23:16]);
		end
		dos = 1'b1;
		write_port({r[31:24], PORT_0F}, ~r[23:16]);
		dos = 1'b0;

		test_name = "paging";
		r = next_random();
		write_port(16'hEFF7, r[7:0] & 8'hFB);
		write_port(16'h7FFD, r[15:8]);
		write_port(16'hFFFD, r[23:16]); // a15 high misses 7ffd
		write_port(16'h7FFD, r[31:24] | 8'h20);
		r = next_random();
		write_port(16'hFFF7, r[31:24]); // a12 high misses eff7
		write_port(16'hEFF7, r[7:0] | 8'h04); // now locked
		write_port(16'h7FFD, r[15:8]);
		dos = 1'b1;
		write_port(16'hEFF7, r[23:16] & 8'hFB);
		dos = 1'b0;

		test_name = "xt_regs";
		r = next_random();
		run_xt_sequence(XT_KEY, XREG_VCONFIG, r[7:0]);
		run_xt_sequence(r[15:8] & 8'h7F, XREG_VCONFIG, ~r[7:0] & 8'h7F); // wrong key
		write_port(XT_PORT, XT_KEY);
		write_port({r[31:24], PORT_FE}, r[7:0]); // breaks the sequence
		write_port(XT_PORT, XREG_VCONFIG);
		write_port(XT_PORT, ~r[7:0] & 8'h7F);
		write_port(XT_PORT, XT_KEY);
		write_port(XT_PORT, XREG_VCONFIG);
		write_port({r[31:24], PORT_FB}, r[23:16]);
		write_port(XT_PORT, ~r[7:0] & 8'h7F);
		r = next_random();
		run_xt_sequence(XT_KEY, XREG_BORDER, r[7:0]);
		read_port({r[15:8], PORT_EF});
		run_xt_sequence(XT_KEY, XREG_VCONFIG, r[23:16]);
		read_port({r[31:24], PORT_EF}); // index moved off the border

		repeat (4) @(negedge zclk);
		$display("errors: %0d wrong values, %0d other failures", err_values, err_other);
		if (err_values == 0 && err_other == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

/* vlog.f */
+incdir+.
zx_ports_pkg.sv
io_strobe.sv
port_decode.sv
xt_sequencer.sv
paging_regs.sv
sound_border_regs.sv
zx_ports_top.sv
tb_zx_ports.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the zx ports testbench with verilator

verilator --binary --timing --assert --timescale 1ns/100ps \
	-f vlog.f --top-module tb_zx_ports -o tb_zx_ports
if [ $? -ne 0 ]; then
	echo "verilator compile failed"
	exit 1
fi

out=$(./obj_dir/tb_zx_ports)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "STATUS: PASS"; then
	exit 0
fi
exit 1
